//--- ahb_to_axi_bridge.f
+incdir+include
hw/ahb_axi_pkg.sv
hw/ahb_addr_phase.sv
hw/ahb_resp_ctrl.sv
hw/axi_cmd_buffer.sv
hw/ahb_to_axi_bridge.sv
verif/axi_slave_model.sv
verif/ahb_to_axi_bridge_tb.sv

//--- verif/ahb_to_axi_bridge_tb.sv
`timescale 1ns/1ps
`include "ahb_axi_consts.svh"

module ahb_to_axi_bridge_tb;
   import ahb_axi_pkg::*;

   logic        ahb_clk;
   logic        reset;
   logic [31:0] haddr;
   logic [31:0] hwdata;
   logic [31:0] hrdata;
   logic [2:0]  hsize;
   logic [1:0]  htrans;
   logic        hwrite;
   logic        hsel;
   logic        hreadyin;
   logic        hreadyout;
   logic        hresp;
   logic        aw_valid;
   logic        aw_ready;
   logic        w_valid;
   logic        w_ready;
   logic        ar_valid;
   logic        ar_ready;
   logic        r_valid;
   axi_addr_t   aw;
   axi_addr_t   ar;
   axi_wbeat_t  w;
   axi_rbeat_t  r;

   logic [31:0] exp_addr [0:63];   // expected writes in issue order
   logic [2:0]  exp_size [0:63];
   logic [31:0] exp_data [0:63];
   logic [3:0]  exp_strb [0:63];
   logic [34:0] exp_rd   [0:15];   // expected AR payloads
   int          wr_cnt;
   int          rd_cnt;
   int          aw_idx;
   int          w_idx;
   int          ar_idx;
   int          cyc;
   string       test_name;

   logic        pend_vld;          // transfer whose data phase comes next
   logic        pend_wr;
   logic        pend_mis;
   logic [31:0] pend_addr;
   logic        dphase_wr;         // kind of the data phase in progress
   logic        dphase_rd_ok;
   logic        dphase_rerr;
   logic        dphase_mis;
   logic [31:0] rd_exp;
   logic [34:0] exp_aw_bits;
   logic [35:0] exp_w_bits;
   logic [34:0] exp_ar_bits;
   logic        buf_busy;

   assign exp_aw_bits = {exp_addr[aw_idx], exp_size[aw_idx]};
   assign exp_w_bits  = {exp_data[w_idx], exp_strb[w_idx]};
   assign exp_ar_bits = exp_rd[ar_idx];
   // some channel still waits for its ready, so the entry stays held
   assign buf_busy = (aw_valid && !aw_ready) || (w_valid && !w_ready) || (ar_valid && !ar_ready);

   always #5 ahb_clk = ~ahb_clk;

   ahb_to_axi_bridge dut0 (
      .ahb_clk (ahb_clk),  .reset (reset),
      .haddr (haddr),  .hsize (hsize),  .htrans (htrans),  .hwrite (hwrite),
      .hwdata (hwdata),  .hsel (hsel),  .hreadyin (hreadyin),
      .hrdata (hrdata),  .hreadyout (hreadyout),  .hresp (hresp),
      .aw_valid (aw_valid),  .aw_ready (aw_ready),  .aw (aw),
      .w_valid (w_valid),  .w_ready (w_ready),  .w (w),
      .ar_valid (ar_valid),  .ar_ready (ar_ready),  .ar (ar),
      .r_valid (r_valid),  .r (r)
   );

   axi_slave_model u_slave (
      .ahb_clk (ahb_clk),  .reset (reset),
      .aw_valid (aw_valid),  .aw_ready (aw_ready),  .aw (aw),
      .w_valid (w_valid),  .w_ready (w_ready),  .w (w),
      .ar_valid (ar_valid),  .ar_ready (ar_ready),  .ar (ar),
      .r_valid (r_valid),  .r (r)
   );

   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
      $display("Test failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_failure(input string what);
      $display("%s: %s", test_name, what);
      $display("Test failed");
      $fatal(1, "stopped at the first error");
   endtask

   function automatic logic [31:0] data_for(input logic [31:0] addr);
      return {addr[15:0], ~addr[15:0]};
   endfunction

   function automatic logic [3:0] lane_mask(input logic [31:0] addr, input logic [2:0] size);
      case (size)
         3'd0:    return 4'b0001 << addr[1:0];
         3'd1:    return 4'b0011 << {addr[1], 1'b0};
         default: return 4'b1111;
      endcase
   endfunction

   // one AHB cycle: new address phase plus data phase of the previous transfer
   task automatic drive_ahb_cycle(input logic vld, input logic [31:0] addr,
                                  input logic [2:0] size, input logic wr);
      logic mis_v;
      int   n;
      mis_v = (size == 3'd1 && addr[0]) || (size == 3'd2 && addr[1:0] != 2'b00);
      dphase_wr    = pend_vld && pend_wr && !pend_mis;
      dphase_rd_ok = pend_vld && !pend_wr && !pend_mis && pend_addr[31:28] != 4'hF;
      dphase_rerr  = pend_vld && !pend_wr && !pend_mis && pend_addr[31:28] == 4'hF;
      dphase_mis   = pend_vld && pend_mis;
      rd_exp       = pend_addr ^ 32'hA5A5_0F0F;
      haddr  = addr;
      hsize  = size;
      hwrite = wr;
      htrans = vld ? `AHB_HTRANS_NONSEQ : `AHB_HTRANS_IDLE;
      hsel   = vld;
      hwdata = data_for(pend_addr);
      if (vld && !mis_v && wr) begin
         exp_addr[wr_cnt] = addr;
         exp_size[wr_cnt] = size;
         exp_data[wr_cnt] = data_for(addr);
         exp_strb[wr_cnt] = lane_mask(addr, size);
         wr_cnt++;
      end
      if (vld && !mis_v && !wr) begin
         exp_rd[rd_cnt] = {addr, size};
         rd_cnt++;
      end
      n = 0;
      @(posedge ahb_clk);
      while (!hreadyout && n < 64) begin
         n++;
         @(posedge ahb_clk);
      end
      if (!hreadyout) begin
         report_failure("hreadyout stayed low and the transfer never completed");
      end
      #1;
      pend_vld  = vld;
      pend_wr   = wr;
      pend_mis  = mis_v;
      pend_addr = addr;
   endtask

   always @(posedge ahb_clk) begin
      cyc <= cyc + 1;
      if (aw_valid && aw_ready) aw_idx <= aw_idx + 1;
      if (w_valid && w_ready) w_idx <= w_idx + 1;
      if (ar_valid && ar_ready) ar_idx <= ar_idx + 1;
   end

   a_reset: assert property (@(posedge ahb_clk) (reset && cyc > 0) || $fell(reset)
      |-> !aw_valid && !w_valid && !ar_valid && hreadyout && !hresp)
      else report_failure("outputs not at their reset values");
   a_aw_extra: assert property (@(posedge ahb_clk) disable iff (reset) aw_valid |-> aw_idx < wr_cnt)
      else report_failure("AW valid for a write that was never issued");
   a_w_extra: assert property (@(posedge ahb_clk) disable iff (reset) w_valid |-> w_idx < wr_cnt)
      else report_failure("W valid for a write that was never issued");
   a_ar_extra: assert property (@(posedge ahb_clk) disable iff (reset) ar_valid |-> ar_idx < rd_cnt)
      else report_failure("AR valid for a read that was never issued");
   a_aw_data: assert property (@(posedge ahb_clk) disable iff (reset)
      aw_valid && aw_ready |-> aw == exp_aw_bits)
      else report_mismatch("AW addr/size", $sampled(exp_aw_bits), $sampled(aw));
   a_w_data: assert property (@(posedge ahb_clk) disable iff (reset)
      w_valid && w_ready |-> w == exp_w_bits)
      else report_mismatch("W data/strb", $sampled(exp_w_bits), $sampled(w));
   a_ar_data: assert property (@(posedge ahb_clk) disable iff (reset)
      ar_valid && ar_ready |-> ar == exp_ar_bits)
      else report_mismatch("AR addr/size", $sampled(exp_ar_bits), $sampled(ar));
   a_aw_hold: assert property (@(posedge ahb_clk) disable iff (reset)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw))
      else report_failure("AW dropped or changed while aw_ready was low");
   a_w_hold: assert property (@(posedge ahb_clk) disable iff (reset)
      w_valid && !w_ready |=> w_valid && $stable(w))
      else report_failure("W dropped or changed while w_ready was low");
   a_ar_hold: assert property (@(posedge ahb_clk) disable iff (reset)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar))
      else report_failure("AR dropped or changed while ar_ready was low");
   a_full_stall: assert property (@(posedge ahb_clk) disable iff (reset)
      dphase_wr && buf_busy |-> !hreadyout)
      else report_failure("write data phase completed while the buffer was full");
   a_rd_ok: assert property (@(posedge ahb_clk) disable iff (reset) dphase_rd_ok |-> !hresp)
      else report_failure("error response on an aligned read");
   a_rd_data: assert property (@(posedge ahb_clk) disable iff (reset)
      dphase_rd_ok && hreadyout |-> hrdata == rd_exp)
      else report_mismatch("read data", $sampled(rd_exp), $sampled(hrdata));
   a_mis_resp: assert property (@(posedge ahb_clk) disable iff (reset) dphase_mis |-> hresp)
      else report_failure("misaligned transfer without hresp");
   a_err_second: assert property (@(posedge ahb_clk) disable iff (reset)
      (dphase_mis || dphase_rerr) && hresp && !hreadyout |=> hresp && hreadyout)
      else report_failure("second error cycle missing");
   a_err_first: assert property (@(posedge ahb_clk) disable iff (reset)
      (dphase_mis || dphase_rerr) && hreadyout |-> hresp && $past(hresp) && !$past(hreadyout))
      else report_failure("error response is not two cycles long");
   a_rerr_src: assert property (@(posedge ahb_clk) disable iff (reset)
      dphase_rerr && hresp && !hreadyout |-> $past(r_valid))
      else report_failure("read error response did not follow r_valid");
   a_mis_quiet: assert property (@(posedge ahb_clk) disable iff (reset)
      dphase_mis |=> !$rose(aw_valid) && !$rose(w_valid) && !$rose(ar_valid))
      else report_failure("AXI valid raised for a misaligned transfer");

   initial begin
      int         i;
      int         n;
      int         off;
      logic [2:0] sz;
      ahb_clk = 1'b0;
      reset = 1'b1;
      haddr = '0;
      hsize = 3'd0;
      htrans = `AHB_HTRANS_IDLE;
      hwrite = 1'b0;
      hwdata = '0;
      hsel = 1'b0;
      hreadyin = 1'b1;            // no other slave can stall the bus
      {pend_vld, pend_wr, pend_mis, pend_addr} = '0;
      {dphase_wr, dphase_rd_ok, dphase_rerr, dphase_mis, rd_exp} = '0;
      {wr_cnt, rd_cnt, aw_idx, w_idx, ar_idx, cyc} = '0;
      test_name = "reset";
      repeat (16) @(posedge ahb_clk);
      #1;
      reset = 1'b0;

      test_name = "single_writes";
      for (i = 0; i < 7; i++) begin
         sz  = (i < 4) ? 3'd0 : (i < 6) ? 3'd1 : 3'd2;
         off = (i < 4) ? i : (i < 6) ? (i - 4) * 2 : 0;
         drive_ahb_cycle(1'b1, 32'h0000_1000 + 16 * i + off, sz, 1'b1);
         drive_ahb_cycle(1'b0, '0, 3'd0, 1'b0);
      end

      test_name = "back_to_back";
      for (i = 0; i < 18; i++) begin
         sz  = i % 3;
         off = (sz == 3'd0) ? i % 4 : (sz == 3'd1) ? (i % 2) * 2 : 0;
         drive_ahb_cycle(1'b1, 32'h0001_0000 + 16 * i + off, sz, 1'b1);
      end
      drive_ahb_cycle(1'b0, '0, 3'd0, 1'b0);

      test_name = "aligned_read";
      drive_ahb_cycle(1'b1, 32'h0000_4000, 3'd2, 1'b0);
      drive_ahb_cycle(1'b1, 32'h1234_5678, 3'd2, 1'b1);   // write right before a read
      drive_ahb_cycle(1'b1, 32'h1234_5678, 3'd2, 1'b0);
      drive_ahb_cycle(1'b1, 32'h0000_4003, 3'd0, 1'b0);
      drive_ahb_cycle(1'b0, '0, 3'd0, 1'b0);

      test_name = "misaligned";
      drive_ahb_cycle(1'b1, 32'h0000_5001, 3'd1, 1'b1);
      drive_ahb_cycle(1'b1, 32'h0000_5002, 3'd2, 1'b1);
      drive_ahb_cycle(1'b1, 32'h0000_5003, 3'd2, 1'b0);
      drive_ahb_cycle(1'b1, 32'h0000_5005, 3'd1, 1'b0);
      drive_ahb_cycle(1'b0, '0, 3'd0, 1'b0);

      test_name = "read_error";
      drive_ahb_cycle(1'b1, 32'hF000_0100, 3'd2, 1'b0);
      drive_ahb_cycle(1'b0, '0, 3'd0, 1'b0);
      drive_ahb_cycle(1'b0, '0, 3'd0, 1'b0);

      test_name = "drain";
      n = 0;
      while ((aw_idx != wr_cnt || w_idx != wr_cnt || ar_idx != rd_cnt) && n < 200) begin
         n++;
         @(posedge ahb_clk);
      end
      #1;
      if (aw_idx == wr_cnt && w_idx == wr_cnt && ar_idx == rd_cnt) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         report_failure("not every issued transfer reached AXI exactly once");
      end
   end

endmodule

//--- verif/axi_slave_model.sv
`timescale 1ns/1ps

module axi_slave_model (
   input  logic                    ahb_clk,
   input  logic                    reset,
   input  logic                    aw_valid,
   output logic                    aw_ready,
   input  ahb_axi_pkg::axi_addr_t  aw,
   input  logic                    w_valid,
   output logic                    w_ready,
   input  ahb_axi_pkg::axi_wbeat_t w,
   input  logic                    ar_valid,
   output logic                    ar_ready,
   input  ahb_axi_pkg::axi_addr_t  ar,
   output logic                    r_valid,
   output ahb_axi_pkg::axi_rbeat_t r
);
   import ahb_axi_pkg::*;

   logic [31:0] lfsr;
   logic [1:0]  aw_wait;
   logic [1:0]  w_wait;
   logic [1:0]  ar_wait;
   logic [1:0]  r_wait;
   logic        r_busy;      // read accepted, beat not yet returned
   logic [31:0] rd_addr;
   logic        aw_hs;
   logic        w_hs;
   logic        ar_hs;
   logic        aw_seen;
   logic        w_seen;
   logic        ar_seen;

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   // two bits give a wait of 0 to 3 cycles
   task draw_wait(output logic [1:0] cnt);
      cnt[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      cnt[1] = lfsr[0];
      lfsr = lfsr_next(lfsr);
   endtask

   initial begin
      lfsr     = 32'd82594;
      aw_ready = 1'b0;
      w_ready  = 1'b0;
      ar_ready = 1'b0;
      r_valid  = 1'b0;
      r        = '0;
   end

   always @(posedge ahb_clk) begin
      aw_hs   = aw_valid & aw_ready;   // what the DUT saw at this edge
      w_hs    = w_valid & w_ready;
      ar_hs   = ar_valid & ar_ready;
      aw_seen = aw_valid;
      w_seen  = w_valid;
      ar_seen = ar_valid;
      if (ar_hs) begin
         rd_addr = ar.addr;
      end
      #1;
      r_valid = 1'b0;
      if (reset) begin
         lfsr    = 32'd82594;
         aw_wait = 2'd0;
         w_wait  = 2'd0;
         ar_wait = 2'd0;
         r_wait  = 2'd0;
         r_busy  = 1'b0;
      end else begin
         if (aw_hs) begin
            draw_wait(aw_wait);
         end else if (aw_seen && aw_wait != 2'd0) begin
            aw_wait = aw_wait - 2'd1;
         end
         if (w_hs) begin
            draw_wait(w_wait);
         end else if (w_seen && w_wait != 2'd0) begin
            w_wait = w_wait - 2'd1;
         end
         if (ar_hs) begin
            draw_wait(ar_wait);
         end else if (ar_seen && ar_wait != 2'd0) begin
            ar_wait = ar_wait - 2'd1;
         end
         if (r_busy) begin
            if (r_wait == 2'd0) begin
               r_valid = 1'b1;
               r.data  = rd_addr ^ 32'hA5A5_0F0F;
               r.err   = (rd_addr[31:28] == 4'hF);   // error region
               r_busy  = 1'b0;
            end else begin
               r_wait = r_wait - 2'd1;
            end
         end
         if (ar_hs) begin
            r_busy = 1'b1;
            draw_wait(r_wait);
         end
      end
      aw_ready = (aw_wait == 2'd0);
      w_ready  = (w_wait == 2'd0);
      ar_ready = (ar_wait == 2'd0);
   end

endmodule

//--- hw/ahb_to_axi_bridge.sv
`timescale 1ns/1ps
`include "ahb_axi_consts.svh"

module ahb_to_axi_bridge (
   input  logic                       ahb_clk,
   input  logic                       reset,
   // AHB-Lite slave
   input  logic [`AHB_AXI_ADDR_W-1:0] haddr,
   input  logic [2:0]                 hsize,
   input  logic [1:0]                 htrans,
   input  logic                       hwrite,
   input  logic [`AHB_AXI_DATA_W-1:0] hwdata,
   input  logic                       hsel,
   input  logic                       hreadyin,
   output logic [`AHB_AXI_DATA_W-1:0] hrdata,
   output logic                       hreadyout,
   output logic                       hresp,
   // AXI4 master
   output logic                       aw_valid,
   input  logic                       aw_ready,
   output ahb_axi_pkg::axi_addr_t     aw,
   output logic                       w_valid,
   input  logic                       w_ready,
   output ahb_axi_pkg::axi_wbeat_t    w,
   output logic                       ar_valid,
   input  logic                       ar_ready,
   output ahb_axi_pkg::axi_addr_t     ar,
   input  logic                       r_valid,
   input  ahb_axi_pkg::axi_rbeat_t    r
);
   import ahb_axi_pkg::*;

   ahb_req_t req;
   logic     active;
   logic     cmd_load;
   logic     cmd_full;
   logic     cmd_write;

   ahb_addr_phase u_addr_phase (
      .ahb_clk   (ahb_clk),
      .reset     (reset),
      .haddr     (haddr),
      .hsize     (hsize),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hsel      (hsel),
      .hreadyin  (hreadyin),
      .hreadyout (hreadyout),
      .req       (req),
      .active    (active)
   );

   ahb_resp_ctrl u_resp_ctrl (
      .ahb_clk   (ahb_clk),
      .reset     (reset),
      .req       (req),
      .active    (active),
      .hreadyin  (hreadyin),
      .cmd_full  (cmd_full),
      .cmd_write (cmd_write),
      .r_valid   (r_valid),
      .r         (r),
      .cmd_load  (cmd_load),
      .hreadyout (hreadyout),
      .hresp     (hresp),
      .hrdata    (hrdata)
   );

   axi_cmd_buffer u_cmd_buffer (
      .ahb_clk   (ahb_clk),
      .reset     (reset),
      .cmd_load  (cmd_load),
      .req       (req),
      .hwdata    (hwdata),
      .cmd_full  (cmd_full),
      .cmd_write (cmd_write),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .aw        (aw),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .w         (w),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .ar        (ar)
   );

endmodule

//--- hw/axi_cmd_buffer.sv
`timescale 1ns/1ps
`include "ahb_axi_consts.svh"

module axi_cmd_buffer (
   input  logic                       ahb_clk,
   input  logic                       reset,
   input  logic                       cmd_load,
   input  ahb_axi_pkg::ahb_req_t      req,
   input  logic [`AHB_AXI_DATA_W-1:0] hwdata,
   output logic                       cmd_full,
   output logic                       cmd_write,
   output logic                       aw_valid,
   input  logic                       aw_ready,
   output ahb_axi_pkg::axi_addr_t     aw,
   output logic                       w_valid,
   input  logic                       w_ready,
   output ahb_axi_pkg::axi_wbeat_t    w,
   output logic                       ar_valid,
   input  logic                       ar_ready,
   output ahb_axi_pkg::axi_addr_t     ar
);
   import ahb_axi_pkg::*;

   axi_cmd_t  entry;
   axi_cmd_t  entry_nxt;
   axi_addr_t addr_pl;
   logic      vld;
   logic      aw_done;
   logic      w_done;
   logic      aw_hs;
   logic      w_hs;
   logic      ar_hs;
   logic      free;

   assign aw_valid = vld & entry.write & ~aw_done;
   assign w_valid  = vld & entry.write & ~w_done;
   assign ar_valid = vld & ~entry.write;

   assign aw_hs = aw_valid & aw_ready;
   assign w_hs  = w_valid & w_ready;
   assign ar_hs = ar_valid & ar_ready;

   // entry frees on its last handshake, so a new load can follow in the same cycle
   assign free     = (vld & entry.write & (aw_done | aw_hs) & (w_done | w_hs)) | ar_hs;
   assign cmd_full = vld & ~free;
   assign cmd_write = entry.write;

   always_comb begin
      entry_nxt       = '0;
      entry_nxt.addr  = req.addr;
      entry_nxt.size  = req.size;
      entry_nxt.write = req.write;
      entry_nxt.wdata = hwdata;   // valid in the data phase
      entry_nxt.wstrb = req.wstrb;
   end

   always_ff @(posedge ahb_clk) begin
      if (reset) begin
         vld     <= 1'b0;
         aw_done <= 1'b0;
         w_done  <= 1'b0;
      end else if (cmd_load) begin
         vld     <= 1'b1;
         aw_done <= 1'b0;
         w_done  <= 1'b0;
      end else begin
         if (free) begin
            vld <= 1'b0;
         end
         if (aw_hs) begin
            aw_done <= 1'b1;   // aw taken, w may still wait
         end
         if (w_hs) begin
            w_done <= 1'b1;
         end
      end
   end

   always_ff @(posedge ahb_clk) begin
      if (cmd_load) begin
         entry <= entry_nxt;
      end
   end

   // AW and AR carry the same payload, only valid differs
   always_comb begin
      addr_pl      = '0;
      addr_pl.addr = entry.addr;
      addr_pl.size = entry.size;
   end

   assign aw = addr_pl;
   assign ar = addr_pl;

   always_comb begin
      w      = '0;
      w.data = entry.wdata;
      w.strb = entry.wstrb;
   end

endmodule

//--- hw/ahb_resp_ctrl.sv
`timescale 1ns/1ps
`include "ahb_axi_consts.svh"

module ahb_resp_ctrl (
   input  logic                       ahb_clk,
   input  logic                       reset,
   input  ahb_axi_pkg::ahb_req_t      req,
   input  logic                       active,
   input  logic                       hreadyin,
   input  logic                       cmd_full,
   input  logic                       cmd_write,
   input  logic                       r_valid,
   input  ahb_axi_pkg::axi_rbeat_t    r,
   output logic                       cmd_load,
   output logic                       hreadyout,
   output logic                       hresp,
   output logic [`AHB_AXI_DATA_W-1:0] hrdata
);
   import ahb_axi_pkg::*;

   bus_state_t                 state;
   bus_state_t                 state_nxt;
   logic                       err_set;    // next cycle is the second error cycle
   logic                       err2_q;
   logic                       r_take;
   logic                       rdone_q;    // read beat captured last cycle
   logic                       rerr_q;
   logic [`AHB_AXI_DATA_W-1:0] rdata_q;

   always_comb begin
      state_nxt = state;
      cmd_load  = 1'b0;
      hreadyout = 1'b1;
      hresp     = 1'b0;
      err_set   = 1'b0;
      r_take    = 1'b0;
      if (err2_q) begin
         hresp = 1'b1;        // second error cycle completes the transfer
      end else if (rdone_q && rerr_q) begin
         hresp     = 1'b1;    // read error, first cycle
         hreadyout = 1'b0;
         err_set   = 1'b1;
      end else if (!rdone_q) begin
         case (state)
            idle: begin
               if (active) begin
                  if (req.misaligned) begin
                     hresp     = 1'b1;
                     hreadyout = 1'b0;
                     err_set   = 1'b1;
                  end else if (req.write) begin
                     if (cmd_full) begin
                        hreadyout = 1'b0;   // previous command still held
                        state_nxt = wr;
                     end else begin
                        cmd_load = 1'b1;
                     end
                  end else begin
                     hreadyout = 1'b0;      // reads always stall
                     if (cmd_full) begin
                        state_nxt = rd;
                     end else begin
                        cmd_load  = 1'b1;
                        state_nxt = pend;
                     end
                  end
               end
            end
            wr: begin
               if (cmd_full) begin
                  hreadyout = 1'b0;
               end else begin
                  cmd_load  = 1'b1;
                  state_nxt = idle;
               end
            end
            rd: begin
               hreadyout = 1'b0;
               if (!cmd_full) begin
                  cmd_load  = 1'b1;
                  state_nxt = pend;
               end
            end
            default: begin                  // pend
               hreadyout = 1'b0;
               if (r_valid && !cmd_write) begin
                  r_take    = 1'b1;
                  state_nxt = idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge ahb_clk) begin
      if (reset) begin
         state   <= idle;
         rdone_q <= 1'b0;
         err2_q  <= 1'b0;
      end else begin
         state   <= state_nxt;
         rdone_q <= r_take;
         err2_q  <= err_set | (err2_q & ~hreadyin);   // hold until the bus takes it
      end
   end

   always_ff @(posedge ahb_clk) begin
      if (r_take) begin
         rdata_q <= r.data;
         rerr_q  <= r.err;
      end
   end

   assign hrdata = rdata_q;

endmodule

//--- hw/ahb_addr_phase.sv
`timescale 1ns/1ps
`include "ahb_axi_consts.svh"

module ahb_addr_phase (
   input  logic                       ahb_clk,
   input  logic                       reset,
   input  logic [`AHB_AXI_ADDR_W-1:0] haddr,
   input  logic [2:0]                 hsize,
   input  logic [1:0]                 htrans,
   input  logic                       hwrite,
   input  logic                       hsel,
   input  logic                       hreadyin,
   input  logic                       hreadyout,
   output ahb_axi_pkg::ahb_req_t      req,
   output logic                       active
);
   import ahb_axi_pkg::*;

   logic                       accept;
   logic                       xfer_valid;
   xfer_size_t                 size_in;
   logic [`AHB_AXI_STRB_W-1:0] strb;
   logic                       misaligned;
   ahb_req_t                   req_nxt;

   assign accept     = hreadyin & hreadyout;   // address phase sampled this edge
   assign xfer_valid = hsel & (htrans != `AHB_HTRANS_IDLE) & (htrans != `AHB_HTRANS_BUSY);
   assign size_in    = xfer_size_t'(hsize);

   // byte lanes touched by the transfer
   always_comb begin
      case (size_in)
         size_byte: strb = 4'b0001 << haddr[1:0];
         size_half: strb = haddr[1] ? 4'b1100 : 4'b0011;
         default:   strb = 4'b1111;
      endcase
   end

   assign misaligned = ((size_in == size_half) & haddr[0]) |
                       ((size_in == size_word) & (|haddr[1:0]));

   always_comb begin
      req_nxt            = '0;
      req_nxt.addr       = haddr;
      req_nxt.size       = size_in;
      req_nxt.write      = hwrite;
      req_nxt.wstrb      = strb;
      req_nxt.misaligned = misaligned;
   end

   // data phase follows every accepted valid transfer
   always_ff @(posedge ahb_clk) begin
      if (reset) begin
         active <= 1'b0;
      end else if (accept) begin
         active <= xfer_valid;   // idle or unselected cycle ends it
      end
   end

   always_ff @(posedge ahb_clk) begin
      if (accept && xfer_valid) begin
         req <= req_nxt;
      end
   end

endmodule

//--- hw/ahb_axi_pkg.sv
`include "ahb_axi_consts.svh"

package ahb_axi_pkg;

   // state of the AHB data phase handling
   typedef enum logic [1:0] {
      idle = 2'b00,   // no data phase in progress
      wr   = 2'b01,   // write stalled on a full buffer
      rd   = 2'b10,   // read waiting for the buffer
      pend = 2'b11    // read issued, waiting for R
   } bus_state_t;

   // same encoding on hsize and axsize
   typedef enum logic [2:0] {
      size_byte = 3'b000,
      size_half = 3'b001,
      size_word = 3'b010
   } xfer_size_t;

   typedef struct packed {
      logic [`AHB_AXI_ADDR_W-1:0] addr;
      xfer_size_t                 size;
      logic                       write;
      logic [`AHB_AXI_STRB_W-1:0] wstrb;
      logic                       misaligned;
   } ahb_req_t;

   typedef struct packed {
      logic [`AHB_AXI_ADDR_W-1:0] addr;
      xfer_size_t                 size;
      logic                       write;
      logic [`AHB_AXI_DATA_W-1:0] wdata;
      logic [`AHB_AXI_STRB_W-1:0] wstrb;
   } axi_cmd_t;

   typedef struct packed {
      logic [`AHB_AXI_ADDR_W-1:0] addr;
      xfer_size_t                 size;
   } axi_addr_t;

   typedef struct packed {
      logic [`AHB_AXI_DATA_W-1:0] data;
      logic [`AHB_AXI_STRB_W-1:0] strb;
   } axi_wbeat_t;

   typedef struct packed {
      logic [`AHB_AXI_DATA_W-1:0] data;
      logic                       err;   // or of the rresp bits
   } axi_rbeat_t;

endpackage

//--- include/ahb_axi_consts.svh
`ifndef AHB_AXI_CONSTS_SVH
`define AHB_AXI_CONSTS_SVH

// bus widths, fixed for the 32-bit bridge
`define AHB_AXI_ADDR_W 32
`define AHB_AXI_DATA_W 32
`define AHB_AXI_STRB_W 4   // one strobe per byte lane

// htrans encodings
`define AHB_HTRANS_IDLE   2'b00
`define AHB_HTRANS_BUSY   2'b01
`define AHB_HTRANS_NONSEQ 2'b10

`endif
